// ==== project.f ====
hamming_pkg.sv
hamming_encoder.sv
code_store.sv
hamming_decoder.sv
ecc_store_top.sv
ecc_store_chk.sv
ecc_store_tb.sv

// ==== Makefile ====
# Verilator build and run for the ECC register store.

VERILATOR  ?= verilator
TOP        ?= ecc_store_tb
FILELIST   ?= project.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
RUN_ARGS   ?= +verilator+error+limit+1000
PASS_STR   ?= SIMULATION PASSED

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_STR)" $(LOG); then \
		echo "Run passed, log in $(LOG)"; \
	else \
		echo "Run failed, log in $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== ecc_store_tb.sv ====
// ECC register store testbench, seeded random traffic checked against a behavioral model.
`timescale 1ns/100ps
`default_nettype none

module ecc_store_tb;
    import hamming_pkg::*;

    localparam int ADDR_W     = 3;
    localparam int N_ADDR     = 1 << ADDR_W;
    localparam int PERIOD     = 20;
    localparam int RST_CYC    = 5;
    localparam int N_ITEMS    = 16;
    localparam int ITEM_CYC   = ENC_LAT + 2; // Write, gap, read.
    localparam int DRAIN      = 4;
    localparam int MIXED_CYC  = 200;
    localparam int SPARSE_CYC = 60;
    localparam int TOTAL_CYC  = RST_CYC + (N_ADDR + DRAIN)
                              + 3 * (N_ITEMS * ITEM_CYC + DRAIN)
                              + (MIXED_CYC + DRAIN) + (SPARSE_CYC + DRAIN);
    localparam int TIMEOUT_NS = 2 * TOTAL_CYC * PERIOD + 1000;

    typedef logic [ADDR_W-1:0] addr_t;

    logic    clk;
    logic    rst_n;
    logic    wr_en;
    addr_t   wr_addr;
    nibble_t wr_data;
    code_t   inj_mask;
    logic    rd_en;
    addr_t   rd_addr;
    logic    rd_valid;
    nibble_t rd_data;
    logic    corrected;

    // Model state, array contents as committed.
    nibble_t shadow_data   [N_ADDR];
    code_t   shadow_code   [N_ADDR];
    int      shadow_faults [N_ADDR];

    // Writes in flight, index 0 is the newest.
    logic    wp_valid [ENC_LAT];
    addr_t   wp_addr  [ENC_LAT];
    nibble_t wp_data  [ENC_LAT];
    code_t   wp_mask  [ENC_LAT];

    // Expected read results, two edges deep.
    logic    rp_valid [2];
    nibble_t rp_data  [2];
    logic    rp_corr  [2];

    string test_name;
    int    error_count;
    int    check_count;

    ecc_store_top #(.ADDR_W(ADDR_W)) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .inj_mask  (inj_mask),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .corrected (corrected)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic code_t encode_word(nibble_t d);
        code_t c;
        c    = '0;
        c[2] = d[0]; // Position 3.
        c[4] = d[1];
        c[5] = d[2];
        c[6] = d[3];
        c[0] = d[0] ^ d[1] ^ d[3]; // p1 over positions 3, 5, 7.
        c[1] = d[0] ^ d[2] ^ d[3];
        c[3] = d[1] ^ d[2] ^ d[3];
        return c;
    endfunction

    // XOR of the positions of all set bits.
    function automatic int syndrome_of(code_t c);
        int s;
        s = 0;
        for (int pos = 1; pos <= 7; pos++) begin
            if (c[pos-1]) begin
                s = s ^ pos;
            end
        end
        return s;
    endfunction

    function automatic nibble_t decode_word(code_t c);
        code_t fixed;
        int    s;
        s     = syndrome_of(c);
        fixed = c;
        if (s != 0) begin
            fixed = fixed ^ code_t'(1 << (s - 1));
        end
        return {fixed[6], fixed[5], fixed[4], fixed[2]};
    endfunction

    function automatic code_t one_hot_mask();
        return code_t'(1 << $urandom_range(6, 0));
    endfunction

    function automatic code_t two_bit_mask();
        int a;
        int b;
        a = $urandom_range(6, 0);
        b = (a + 1 + $urandom_range(5, 0)) % 7; // Always differs from a.
        return code_t'((1 << a) | (1 << b));
    endfunction

    task automatic check_value(string name, int expected, int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("FAILED %s: expected %0h, actual %0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    task automatic drive_cycle(logic we, addr_t wa, nibble_t wd, code_t mask,
                               logic re, addr_t ra);
        wr_en    = we;
        wr_addr  = wa;
        wr_data  = wd;
        inj_mask = mask;
        rd_en    = re;
        rd_addr  = ra;
        @(posedge clk);
        #2;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) drive_cycle(1'b0, '0, '0, '0, 1'b0, '0);
    endtask

    task automatic write_then_read(addr_t a, nibble_t d, code_t mask);
        drive_cycle(1'b1, a, d, mask, 1'b0, '0);
        idle_cycles(ENC_LAT);
        drive_cycle(1'b0, '0, '0, '0, 1'b1, a);
    endtask

    // Reference model and output checks, all at the rising edge.
    always @(posedge clk) begin
        addr_t ca;
        if (!rst_n) begin
            for (int i = 0; i < N_ADDR; i++) begin
                shadow_data[i]   = '0;
                shadow_code[i]   = '0;
                shadow_faults[i] = 0;
            end
            for (int i = 0; i < ENC_LAT; i++) begin
                wp_valid[i] = 1'b0;
            end
            rp_valid[0] = 1'b0;
            rp_valid[1] = 1'b0;
        end else begin
            // Outputs belong to the read sampled two edges ago.
            check_value({test_name, "/rd_valid"}, int'(rp_valid[1]), int'(rd_valid));
            if (rp_valid[1]) begin
                check_value({test_name, "/rd_data"}, int'(rp_data[1]), int'(rd_data));
                check_value({test_name, "/corrected"}, int'(rp_corr[1]), int'(corrected));
            end else begin
                check_value({test_name, "/corrected"}, 0, int'(corrected));
            end
            rp_valid[1] = rp_valid[0];
            rp_data[1]  = rp_data[0];
            rp_corr[1]  = rp_corr[0];
            rp_valid[0] = rd_en;
            if (rd_en) begin
                // Two flips are miscorrected by the decoding rule.
                if (shadow_faults[rd_addr] < 2) begin
                    rp_data[0] = shadow_data[rd_addr];
                end else begin
                    rp_data[0] = decode_word(shadow_code[rd_addr]);
                end
                rp_corr[0] = (shadow_faults[rd_addr] != 0);
            end

            // Oldest write lands now, after the read above saw the old word.
            if (wp_valid[ENC_LAT-1]) begin
                ca                = wp_addr[ENC_LAT-1];
                shadow_data[ca]   = wp_data[ENC_LAT-1];
                shadow_code[ca]   = encode_word(wp_data[ENC_LAT-1]) ^ wp_mask[ENC_LAT-1];
                shadow_faults[ca] = $countones(wp_mask[ENC_LAT-1]);
            end
            for (int i = ENC_LAT - 1; i > 0; i--) begin
                wp_valid[i] = wp_valid[i-1];
                wp_addr[i]  = wp_addr[i-1];
                wp_data[i]  = wp_data[i-1];
                wp_mask[i]  = wp_mask[i-1];
            end
            wp_valid[0] = wr_en;
            wp_addr[0]  = wr_addr;
            wp_data[0]  = wr_data;
            wp_mask[0]  = inj_mask;
        end
    end

    initial begin
        logic    we;
        logic    re;
        addr_t   wa;
        addr_t   ra;
        nibble_t wd;
        code_t   mask;
        addr_t   recent [ENC_LAT];

        void'($urandom(98));
        clk         = 1'b0;
        rst_n       = 1'b0;
        wr_en       = 1'b0;
        wr_addr     = '0;
        wr_data     = '0;
        inj_mask    = '0;
        rd_en       = 1'b0;
        rd_addr     = '0;
        error_count = 0;
        check_count = 0;
        test_name   = "reset";
        for (int i = 0; i < ENC_LAT; i++) begin
            recent[i] = '0;
        end
        repeat (RST_CYC) @(posedge clk);
        #2;
        rst_n = 1'b1;

        test_name = "reset_read";
        for (int a = 0; a < N_ADDR; a++) begin
            drive_cycle(1'b0, '0, '0, '0, 1'b1, addr_t'(a));
        end
        idle_cycles(DRAIN);

        test_name = "clean_write";
        repeat (N_ITEMS) begin
            write_then_read(addr_t'($urandom_range(N_ADDR - 1, 0)),
                            nibble_t'($urandom_range(15, 0)), '0);
        end
        idle_cycles(DRAIN);

        test_name = "single_fault";
        repeat (N_ITEMS) begin
            write_then_read(addr_t'($urandom_range(N_ADDR - 1, 0)),
                            nibble_t'($urandom_range(15, 0)), one_hot_mask());
        end
        idle_cycles(DRAIN);

        test_name = "double_fault";
        repeat (N_ITEMS) begin
            write_then_read(addr_t'($urandom_range(N_ADDR - 1, 0)),
                            nibble_t'($urandom_range(15, 0)), two_bit_mask());
        end
        idle_cycles(DRAIN);

        // Reads often target an address whose write is still in flight.
        test_name = "back_to_back";
        for (int i = 0; i < MIXED_CYC; i++) begin
            we = ($urandom_range(3, 0) != 0);
            wa = addr_t'($urandom_range(N_ADDR - 1, 0));
            wd = nibble_t'($urandom_range(15, 0));
            case ($urandom_range(3, 0))
                2:       mask = one_hot_mask();
                3:       mask = two_bit_mask();
                default: mask = '0;
            endcase
            re = ($urandom_range(3, 0) != 0);
            if ($urandom_range(1, 0) == 1) begin
                ra = recent[$urandom_range(ENC_LAT - 1, 0)];
            end else begin
                ra = addr_t'($urandom_range(N_ADDR - 1, 0));
            end
            drive_cycle(we, wa, wd, mask, re, ra);
            for (int k = ENC_LAT - 1; k > 0; k--) begin
                recent[k] = recent[k-1];
            end
            recent[0] = wa;
        end
        idle_cycles(DRAIN);

        test_name = "strobe_timing";
        for (int i = 0; i < SPARSE_CYC; i++) begin
            re = ($urandom_range(2, 0) == 0);
            drive_cycle(1'b0, '0, '0, '0, re, addr_t'($urandom_range(N_ADDR - 1, 0)));
        end
        idle_cycles(DRAIN);

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, UUT.u_chk.failures);
        if (error_count == 0 && UUT.u_chk.failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== ecc_store_chk.sv ====
// Assertions on ECC store reset state and strobe timing, bound into the top level.
`timescale 1ns/100ps
`default_nettype none

module ecc_store_chk (
    input logic clk,
    input logic rst_n,
    input logic wr_en,
    input logic rd_en,
    input logic enc_valid,
    input logic rd_valid,
    input logic corrected
);
    import hamming_pkg::*;

    int failures = 0;

    // Reset clears the read strobe asynchronously.
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !rd_valid)
        else begin
            failures++;
            $error("rd_valid high while reset is asserted");
        end

    a_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid == $past(rd_en, 2))
        else begin
            failures++;
            $error("rd_valid does not follow rd_en by two cycles");
        end

    a_corrected_qualified: assert property (@(posedge clk) disable iff (!rst_n)
        corrected |-> rd_valid)
        else begin
            failures++;
            $error("corrected high without rd_valid");
        end

    // Encoder valid trails the write strobe by the pipeline depth.
    a_encoder_latency: assert property (@(posedge clk) disable iff (!rst_n)
        enc_valid == $past(wr_en, ENC_LAT))
        else begin
            failures++;
            $error("enc_valid does not follow wr_en by the encoder depth");
        end

endmodule

bind ecc_store_top ecc_store_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en     (wr_en),
    .rd_en     (rd_en),
    .enc_valid (enc_valid),
    .rd_valid  (rd_valid),
    .corrected (corrected)
);

`default_nettype wire

// ==== ecc_store_top.sv ====
// ECC register store top level, encoder into code word array into decoder.
`timescale 1ns/100ps
`default_nettype none

// A write sampled at edge N lands in the array ENC_LAT edges later.
// Reads sampled ENC_LAT+1 or more edges after it return the new word.
// Reads return data two edges after rd_en is sampled.
module ecc_store_top #(
    parameter int ADDR_W = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  logic [ADDR_W-1:0]    wr_addr,
    input  hamming_pkg::nibble_t wr_data,
    input  hamming_pkg::code_t   inj_mask,
    input  logic                 rd_en,
    input  logic [ADDR_W-1:0]    rd_addr,
    output logic                 rd_valid,
    output hamming_pkg::nibble_t rd_data,
    output logic                 corrected
);
    import hamming_pkg::*;

    logic              enc_valid;
    logic [ADDR_W-1:0] enc_addr;
    code_t             enc_code;
    code_t             enc_mask;

    logic              st_valid;
    code_t             st_code;

    hamming_encoder #(.ADDR_W(ADDR_W)) u_encoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .inj_mask  (inj_mask),
        .enc_valid (enc_valid),
        .enc_addr  (enc_addr),
        .enc_code  (enc_code),
        .enc_mask  (enc_mask)
    );

    code_store #(.ADDR_W(ADDR_W)) u_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .enc_valid (enc_valid),
        .enc_addr  (enc_addr),
        .enc_code  (enc_code),
        .enc_mask  (enc_mask),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .st_valid  (st_valid),
        .st_code   (st_code)
    );

    hamming_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .st_valid  (st_valid),
        .st_code   (st_code),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .corrected (corrected)
    );

endmodule

`default_nettype wire

// ==== hamming_decoder.sv ====
// Hamming (7,4) read-side decoder, single-error correction and data extraction.
`timescale 1ns/100ps
`default_nettype none

module hamming_decoder (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 st_valid,
    input  hamming_pkg::code_t   st_code,
    output logic                 rd_valid,
    output hamming_pkg::nibble_t rd_data,
    output logic                 corrected
);
    import hamming_pkg::*;

    syndrome_t syn;
    code_t     flip;
    code_t     fixed_code;
    nibble_t   fixed_data;

    // Each group including its parity bit must be even.
    assign syn[0] = ^(st_code & P1_GRP);
    assign syn[1] = ^(st_code & P2_GRP);
    assign syn[2] = ^(st_code & P4_GRP);

    // One-hot mask at the position the syndrome points to.
    always_comb begin
        flip = '0;
        for (int i = 0; i < 7; i++) begin
            if (syn == syndrome_t'(i + 1)) begin
                flip[i] = 1'b1;
            end
        end
    end

    assign fixed_code = st_code ^ flip;

    assign fixed_data[0] = fixed_code[POS_D0];
    assign fixed_data[1] = fixed_code[POS_D1];
    assign fixed_data[2] = fixed_code[POS_D2];
    assign fixed_data[3] = fixed_code[POS_D3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid  <= 1'b0;
            corrected <= 1'b0;
        end else begin
            rd_valid  <= st_valid;
            corrected <= st_valid && (syn != '0); // Only flagged on a real read.
        end
    end

    always_ff @(posedge clk) begin
        if (st_valid) begin
            rd_data <= fixed_data;
        end
    end

endmodule

`default_nettype wire

// ==== code_store.sv ====
// Code word array with fault-mask write port and registered read port.
`timescale 1ns/100ps
`default_nettype none

module code_store #(
    parameter int ADDR_W = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               enc_valid,
    input  logic [ADDR_W-1:0]  enc_addr,
    input  hamming_pkg::code_t enc_code,
    input  hamming_pkg::code_t enc_mask,
    input  logic               rd_en,
    input  logic [ADDR_W-1:0]  rd_addr,
    output logic               st_valid,
    output hamming_pkg::code_t st_code
);
    import hamming_pkg::*;

    localparam int DEPTH = 1 << ADDR_W;

    code_t mem [DEPTH];

    // Zero is the code word of data 0, so a cleared array reads clean.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (enc_valid) begin
            mem[enc_addr] <= enc_code ^ enc_mask; // Injected faults land here.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_valid <= 1'b0;
        end else begin
            st_valid <= rd_en;
        end
    end

    // Old contents are returned when a write commits on the same edge.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            st_code <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== hamming_encoder.sv ====
// Hamming (7,4) write-side encoder, three registered stages from request to code word.
`timescale 1ns/100ps
`default_nettype none

module hamming_encoder #(
    parameter int ADDR_W = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  logic [ADDR_W-1:0]   wr_addr,
    input  hamming_pkg::nibble_t wr_data,
    input  hamming_pkg::code_t  inj_mask,
    output logic                enc_valid,
    output logic [ADDR_W-1:0]   enc_addr,
    output hamming_pkg::code_t  enc_code,
    output hamming_pkg::code_t  enc_mask
);
    import hamming_pkg::*;

    logic              s1_valid;
    logic [ADDR_W-1:0] s1_addr;
    nibble_t           s1_data;
    code_t             s1_mask;

    logic              s2_valid;
    logic [ADDR_W-1:0] s2_addr;
    code_t             s2_code; // Data in place, parity still zero.
    code_t             s2_mask;

    // Valid bits per stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            enc_valid <= 1'b0;
        end else begin
            s1_valid  <= wr_en;
            s2_valid  <= s1_valid;
            enc_valid <= s2_valid;
        end
    end

    // Stage 1, request latch.
    always_ff @(posedge clk) begin
        s1_addr <= wr_addr;
        s1_data <= wr_data;
        s1_mask <= inj_mask;
    end

    // Stage 2, spread data bits over positions 3, 5, 6 and 7.
    always_ff @(posedge clk) begin
        s2_addr         <= s1_addr;
        s2_mask         <= s1_mask;
        s2_code         <= '0;
        s2_code[POS_D0] <= s1_data[0];
        s2_code[POS_D1] <= s1_data[1];
        s2_code[POS_D2] <= s1_data[2];
        s2_code[POS_D3] <= s1_data[3];
    end

    // Stage 3, parity bits beside the data.
    always_ff @(posedge clk) begin
        enc_addr         <= s2_addr;
        enc_mask         <= s2_mask;
        enc_code         <= s2_code & DATA_POS;
        enc_code[POS_P1] <= ^(s2_code & P1_GRP); // Even parity.
        enc_code[POS_P2] <= ^(s2_code & P2_GRP);
        enc_code[POS_P4] <= ^(s2_code & P4_GRP);
    end

endmodule

`default_nettype wire

// ==== hamming_pkg.sv ====
// Hamming (7,4) shared types, code word bit positions and parity group masks.
`default_nettype none

package hamming_pkg;

    typedef logic [3:0] nibble_t;   // One user data word.
    typedef logic [6:0] code_t;     // Bit i holds Hamming position i+1.
    typedef logic [2:0] syndrome_t; // 1-based position of a flipped bit.

    // Encoder pipeline depth.
    localparam int ENC_LAT = 3;

    // Bit indices inside code_t.
    localparam int POS_P1 = 0;
    localparam int POS_P2 = 1;
    localparam int POS_D0 = 2;
    localparam int POS_P4 = 3;
    localparam int POS_D1 = 4;
    localparam int POS_D2 = 5;
    localparam int POS_D3 = 6;

    // Even parity groups including their own parity bit.
    // P1 covers positions 1,3,5,7.
    localparam code_t P1_GRP = 7'b1010101;
    // P2 covers positions 2,3,6,7.
    localparam code_t P2_GRP = 7'b1100110;
    // P4 covers positions 4,5,6,7.
    localparam code_t P4_GRP = 7'b1111000;

    // Data positions only.
    localparam code_t DATA_POS = 7'b1110100;

endpackage

`default_nettype wire
